// File: verilog/arb_dims_pkg.sv
// arbitration pipeline sizing defaults and index width helper
`default_nettype none

package arb_dims_pkg;

  // --------------------
  // sizing defaults
  // --------------------

  // requesters seen by the arbiter
  parameter int NUM_REQ_DEFAULT = 5;

  // payload word carried per requester
  parameter int DATA_W_DEFAULT = 16;

  // --------------------
  // helpers
  // --------------------

  // log2 rounded up, never below one bit
  // a single requester still needs a 1-bit index
  function automatic int clamped_clog2(input int value);
    if (value <= 1) begin
      return 1;
    end
    return $clog2(value);
  endfunction

endpackage : arb_dims_pkg

`default_nettype wire

// File: verilog/arb_result_pkg.sv
// result codes returned with each arbitration outcome
`default_nettype none

package arb_result_pkg;

  // width of the result code bus
  parameter int RESULT_W = 2;

  // --------------------
  // code values
  // --------------------

  // strobe seen but no requester present
  parameter logic [RESULT_W-1:0] RES_IDLE = 2'd0;

  // exactly one requester, granted without contention
  parameter logic [RESULT_W-1:0] RES_SOLE = 2'd1;

  // more than one requester, round robin picked the winner
  parameter logic [RESULT_W-1:0] RES_CONTENDED = 2'd2;

  // code 3 unused

endpackage : arb_result_pkg

`default_nettype wire

// File: verilog/req_capture_stage.sv
// input stage, registers the strobe, request vector and payload bus
`default_nettype none

module req_capture_stage #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // upstream strobe and buses
  input  logic                      in_valid,
  input  logic [num_req-1:0]        in_req,
  input  logic [num_req*data_w-1:0] in_data,
  // toward the grant stage
  output logic                      cap_valid,
  output logic [num_req-1:0]        cap_req,
  output logic [num_req*data_w-1:0] cap_data
);

  // --------------------
  // strobe register
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= in_valid;
    end
  end

  // --------------------
  // request and payload
  // --------------------

  // request vector masked off between strobes
  // so the grant stage never sees stale requests
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_req <= '0;
    end else begin
      cap_req <= in_valid ? in_req : '0;
    end
  end

  // payload only sampled on a strobe, holds otherwise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_data <= '0;
    end else if (in_valid) begin
      cap_data <= in_data;
    end
  end

endmodule : req_capture_stage

`default_nettype wire

// File: verilog/rr_grant_stage.sv
// round-robin arbiter stage with registered onehot grant
`default_nettype none

module rr_grant_stage #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // from the capture stage
  input  logic                      cap_valid,
  input  logic [num_req-1:0]        cap_req,
  input  logic [num_req*data_w-1:0] cap_data,
  // toward the encoder stage
  output logic                      gnt_valid,
  output logic [num_req-1:0]        gnt_onehot,
  output logic [num_req*data_w-1:0] gnt_data,
  output logic                      gnt_multi
);

  import arb_dims_pkg::*;

  // pointer just wide enough for num_req positions
  localparam int ptr_w = clamped_clog2(num_req);

  // --------------------
  // state and next-state
  // --------------------

  // first requester eligible for the next grant
  logic [ptr_w-1:0]   rr_ptr;
  logic [ptr_w-1:0]   rr_ptr_nxt;
  logic [num_req-1:0] grant_comb;
  logic               any_req;
  logic               multi_req;

  assign any_req = |cap_req;

  // more than one bit set in the request vector
  assign multi_req = $countones(cap_req) > 1;

  // --------------------
  // grant search
  // --------------------

  // walk from the pointer upward, wrapping at num_req
  // first hit wins, later hits ignored
  always_comb begin
    int  cand;
    logic found;
    grant_comb = '0;
    rr_ptr_nxt = rr_ptr;
    found      = 1'b0;
    for (int off = 0; off < num_req; off++) begin
      cand = int'(rr_ptr) + off;
      if (cand >= num_req) begin
        cand = cand - num_req;
      end
      if (!found && cap_req[cand]) begin
        found            = 1'b1;
        grant_comb[cand] = 1'b1;
        // pointer lands one past the winner
        if (cand + 1 == num_req) begin
          rr_ptr_nxt = '0;
        end else begin
          rr_ptr_nxt = ptr_w'(cand + 1);
        end
      end
    end
  end

  // --------------------
  // registers
  // --------------------

  // pointer moves only when something was granted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (cap_valid && any_req) begin
      rr_ptr <= rr_ptr_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_valid  <= 1'b0;
      gnt_onehot <= '0;
      gnt_data   <= '0;
      gnt_multi  <= 1'b0;
    end else begin
      gnt_valid <= cap_valid;
      if (cap_valid) begin
        // all-zero grant when no requests
        gnt_onehot <= grant_comb;
        gnt_data   <= cap_data;
        gnt_multi  <= multi_req;
      end
    end
  end

endmodule : rr_grant_stage

`default_nettype wire

// File: verilog/grant_encode_stage.sv
// registered onehot-0 to binary encoder, payload and flags ride along
`default_nettype none

module grant_encode_stage #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT,
  // wider than the minimum zero-extends the index
  parameter int idx_w   = arb_dims_pkg::clamped_clog2(num_req)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // from the grant stage
  input  logic                      gnt_valid,
  input  logic [num_req-1:0]        gnt_onehot,
  input  logic [num_req*data_w-1:0] gnt_data,
  input  logic                      gnt_multi,
  // toward the payload select stage
  output logic                      enc_valid,
  output logic                      enc_any,
  output logic [idx_w-1:0]          enc_index,
  output logic [num_req*data_w-1:0] enc_data,
  output logic                      enc_multi
);

  // --------------------
  // encoder
  // --------------------

  logic [idx_w-1:0] index_comb;
  logic             any_comb;

  // all zeros gives index 0 with any low
  assign any_comb = |gnt_onehot;

  // OR in each set bit's position
  // bit 0 contributes nothing, so start at 1
  always_comb begin
    index_comb = '0;
    for (int i = 1; i < num_req; i++) begin
      if (gnt_onehot[i]) begin
        index_comb |= idx_w'(i);
      end
    end
  end

  // --------------------
  // output registers
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enc_valid <= 1'b0;
      enc_any   <= 1'b0;
      enc_index <= '0;
      enc_data  <= '0;
      enc_multi <= 1'b0;
    end else begin
      enc_valid <= gnt_valid;
      if (gnt_valid) begin
        enc_any   <= any_comb;
        enc_index <= index_comb;
        enc_data  <= gnt_data;
        enc_multi <= gnt_multi;
      end
    end
  end

endmodule : grant_encode_stage

`default_nettype wire

// File: verilog/payload_select_stage.sv
// last stage, picks the winner's payload and forms the result code
`default_nettype none

module payload_select_stage #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT,
  parameter int idx_w   = arb_dims_pkg::clamped_clog2(num_req)
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // from the encoder stage
  input  logic                              enc_valid,
  input  logic                              enc_any,
  input  logic [idx_w-1:0]                  enc_index,
  input  logic [num_req*data_w-1:0]         enc_data,
  input  logic                              enc_multi,
  // top-level outputs
  output logic                              out_valid,
  output logic                              out_grant_valid,
  output logic [idx_w-1:0]                  out_index,
  output logic [data_w-1:0]                 out_data,
  output logic [arb_result_pkg::RESULT_W-1:0] out_result
);

  import arb_result_pkg::*;

  logic [data_w-1:0]   sel_data;
  logic [RESULT_W-1:0] res_code;

  // --------------------
  // payload mux
  // --------------------

  // compare against each slot so an out-of-range index selects nothing
  // zero when nobody was granted
  always_comb begin
    sel_data = '0;
    for (int k = 0; k < num_req; k++) begin
      if (enc_any && (enc_index == idx_w'(k))) begin
        sel_data = enc_data[k*data_w +: data_w];
      end
    end
  end

  // --------------------
  // result code
  // --------------------

  // idle takes precedence, multi flag only matters with a grant
  always_comb begin
    if (!enc_any) begin
      res_code = RES_IDLE;
    end else if (enc_multi) begin
      res_code = RES_CONTENDED;
    end else begin
      res_code = RES_SOLE;
    end
  end

  // --------------------
  // output registers
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid       <= 1'b0;
      out_grant_valid <= 1'b0;
      out_index       <= '0;
      out_data        <= '0;
      out_result      <= RES_IDLE;
    end else begin
      out_valid <= enc_valid;
      if (enc_valid) begin
        out_grant_valid <= enc_any;
        out_index       <= enc_index;
        out_data        <= sel_data;
        out_result      <= res_code;
      end
    end
  end

endmodule : payload_select_stage

`default_nettype wire

// File: verilog/arb_pipe_top.sv
// four-stage round-robin request arbitration pipeline
`default_nettype none

module arb_pipe_top #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT,
  // at least clamped_clog2(num_req)
  parameter int idx_w   = arb_dims_pkg::clamped_clog2(num_req)
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // single-cycle request strobe
  input  logic                                in_valid,
  input  logic [num_req-1:0]                  in_req,
  // requester k in slice k
  input  logic [num_req*data_w-1:0]           in_data,
  // result strobe, four cycles after in_valid
  output logic                                out_valid,
  output logic                                out_grant_valid,
  output logic [idx_w-1:0]                    out_index,
  output logic [data_w-1:0]                   out_data,
  output logic [arb_result_pkg::RESULT_W-1:0] out_result
);

  // --------------------
  // stage wires
  // --------------------

  // capture -> grant
  logic                      cap_valid;
  logic [num_req-1:0]        cap_req;
  logic [num_req*data_w-1:0] cap_data;

  // grant -> encode
  logic                      gnt_valid;
  logic [num_req-1:0]        gnt_onehot;
  logic [num_req*data_w-1:0] gnt_data;
  logic                      gnt_multi;

  // encode -> select
  logic                      enc_valid;
  logic                      enc_any;
  logic [idx_w-1:0]          enc_index;
  logic [num_req*data_w-1:0] enc_data;
  logic                      enc_multi;

  // --------------------
  // stages
  // --------------------

  req_capture_stage #(.num_req(num_req), .data_w(data_w)) i_capture (
    .clk, .rst_n, .in_valid, .in_req, .in_data,
    .cap_valid, .cap_req, .cap_data
  );

  rr_grant_stage #(.num_req(num_req), .data_w(data_w)) i_grant (
    .clk, .rst_n, .cap_valid, .cap_req, .cap_data,
    .gnt_valid, .gnt_onehot, .gnt_data, .gnt_multi
  );

  grant_encode_stage #(.num_req(num_req), .data_w(data_w), .idx_w(idx_w)) i_encode (
    .clk, .rst_n, .gnt_valid, .gnt_onehot, .gnt_data, .gnt_multi,
    .enc_valid, .enc_any, .enc_index, .enc_data, .enc_multi
  );

  payload_select_stage #(.num_req(num_req), .data_w(data_w), .idx_w(idx_w)) i_select (
    .clk, .rst_n, .enc_valid, .enc_any, .enc_index, .enc_data, .enc_multi,
    .out_valid, .out_grant_valid, .out_index, .out_data, .out_result
  );

endmodule : arb_pipe_top

`default_nettype wire

// File: tests/arb_pipe_props.sv
// concurrent assertions on grant shape, index range and pipeline latency
`default_nettype none

module arb_pipe_props #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int idx_w   = arb_dims_pkg::clamped_clog2(num_req)
) (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input logic [num_req-1:0] gnt_onehot,
  input logic [idx_w-1:0]   enc_index,
  input logic               out_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // edges since reset release, saturates at 4
  // latency check waits until 4 clean samples exist
  logic [2:0] settle;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      settle <= '0;
    end else if (settle != 3'd4) begin
      settle <= settle + 3'd1;
    end
  end

  // --------------------
  // properties
  // --------------------

  a_grant_onehot0 : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(gnt_onehot))
    else $error("grant vector has more than one bit set");

  a_index_range : assert property (@(posedge clk) disable iff (!rst_n)
    int'(enc_index) < num_req)
    else $error("encoded index points past the last requester");

  // strobe spacing preserved, four stages deep
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    (settle == 3'd4) |-> (out_valid == $past(in_valid, 4)))
    else $error("out_valid does not follow in_valid by four cycles");

endmodule : arb_pipe_props

bind arb_pipe_top arb_pipe_props #(.num_req(num_req), .idx_w(idx_w)) i_props (
  .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
  .gnt_onehot(gnt_onehot), .enc_index(enc_index), .out_valid(out_valid)
);

`default_nettype wire

// File: tests/arb_pipe_checker.sv
// reference model and output comparison for the arbitration pipeline
`default_nettype none

module arb_pipe_checker #(
  parameter int num_req = arb_dims_pkg::NUM_REQ_DEFAULT,
  parameter int data_w  = arb_dims_pkg::DATA_W_DEFAULT,
  parameter int idx_w   = arb_dims_pkg::clamped_clog2(num_req),
  parameter int name_w  = 96
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // DUT inputs, watched
  input  logic                                in_valid,
  input  logic [num_req-1:0]                  in_req,
  input  logic [num_req*data_w-1:0]           in_data,
  // DUT outputs
  input  logic                                out_valid,
  input  logic                                out_grant_valid,
  input  logic [idx_w-1:0]                    out_index,
  input  logic [data_w-1:0]                   out_data,
  input  logic [arb_result_pkg::RESULT_W-1:0] out_result,
  // current table entry
  input  logic [name_w-1:0]                   test_name,
  input  logic [arb_result_pkg::RESULT_W-1:0] exp_result,
  output int                                  err_count,
  output int                                  chk_count,
  output int                                  pending
);
  timeunit 1ns;
  timeprecision 1ps;

  import arb_result_pkg::*;

  localparam int latency = 4;

  int rr_ptr = 0;
  int cycle  = 0;
  int errs   = 0;
  int checks = 0;
  int depth  = 0;

  // one entry per strobe still in flight
  logic [name_w-1:0]   q_name [$];
  logic [RESULT_W-1:0] q_res [$];
  logic                q_any [$];
  int                  q_idx [$];
  logic [data_w-1:0]   q_data [$];
  int                  q_cycle [$];

  assign err_count = errs;
  assign chk_count = checks;
  assign pending   = depth;

  task automatic report_value(input logic [name_w-1:0] name, input string field,
                              input logic [31:0] exp_v, input logic [31:0] act_v);
    $display("ERR %0s %0s: expected 0x%0h, actual 0x%0h", name, field, exp_v, act_v);
    errs++;
  endtask

  // oldest prediction against what just came out
  task automatic compare_front();
    logic [name_w-1:0] name;
    int                idx;
    int                born;
    name = q_name.pop_front();
    idx  = q_idx.pop_front();
    born = q_cycle.pop_front();
    if (out_grant_valid !== q_any[0]) begin
      report_value(name, "grant_valid", 32'(q_any[0]), 32'(out_grant_valid));
    end
    if (out_index !== idx_w'(idx)) begin
      report_value(name, "index", 32'(idx), 32'(out_index));
    end
    if (out_data !== q_data[0]) begin
      report_value(name, "data", 32'(q_data[0]), 32'(out_data));
    end
    if (out_result !== q_res[0]) begin
      report_value(name, "result", 32'(q_res[0]), 32'(out_result));
    end
    if (cycle - born != latency) begin
      report_value(name, "latency", 32'(latency), 32'(cycle - born));
    end
    void'(q_any.pop_front());
    void'(q_data.pop_front());
    void'(q_res.pop_front());
    checks++;
  endtask

  // --------------------
  // model
  // --------------------

  always @(posedge clk) begin : watch
    int   win;
    int   cand;
    logic found;
    cycle++;
    if (!rst_n) begin
      if (q_idx.size() != 0) begin
        $display("reset hit while %0d results were still in the pipeline", q_idx.size());
        errs++;
      end
      // pointer back to requester 0
      rr_ptr = 0;
      q_name.delete();
      q_res.delete();
      q_any.delete();
      q_idx.delete();
      q_data.delete();
      q_cycle.delete();
    end else begin
      if (out_valid) begin
        if (q_idx.size() == 0) begin
          $display("out_valid seen at cycle %0d with no arbitration pending", cycle);
          errs++;
        end else begin
          compare_front();
        end
      end
      if (in_valid) begin
        found = 1'b0;
        win   = 0;
        // first requester at or after the pointer, modulo num_req
        for (int off = 0; off < num_req; off++) begin
          cand = (rr_ptr + off) % num_req;
          if (!found && in_req[cand]) begin
            found = 1'b1;
            win   = cand;
          end
        end
        if (found) begin
          rr_ptr = (win + 1) % num_req;
        end
        q_name.push_back(test_name);
        q_res.push_back(exp_result);
        q_any.push_back(found);
        q_idx.push_back(win);
        q_data.push_back(found ? in_data[win*data_w +: data_w] : '0);
        q_cycle.push_back(cycle);
      end
    end
    depth = q_idx.size();
  end

endmodule : arb_pipe_checker

`default_nettype wire

// File: tests/arb_pipe_tb.sv
// testbench top for the round-robin arbitration pipeline
`default_nettype none

module arb_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import arb_dims_pkg::*;
  import arb_result_pkg::*;

  localparam int          num_req   = NUM_REQ_DEFAULT;
  localparam int          data_w    = DATA_W_DEFAULT;
  localparam int          idx_w     = clamped_clog2(num_req);
  localparam int          n_tests   = 19;
  localparam int          name_w    = 8 * 12;
  localparam logic [31:0] lfsr_seed = 32'h1153_9da4;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic [num_req-1:0]        in_req;
  logic [num_req*data_w-1:0] in_data;
  logic                      out_valid;
  logic                      out_grant_valid;
  logic [idx_w-1:0]          out_index;
  logic [data_w-1:0]         out_data;
  logic [RESULT_W-1:0]       out_result;
  logic [name_w-1:0]         cur_name;
  logic [RESULT_W-1:0]       cur_exp;
  int                        err_count;
  int                        chk_count;
  int                        pending;
  int                        tb_errs;
  logic [31:0]               lfsr_state;

  // --------------------
  // stimulus table
  // --------------------

  logic [name_w-1:0]   tbl_name [n_tests];
  logic [num_req-1:0]  tbl_req [n_tests];
  int                  tbl_gap [n_tests];
  // reset pulse ahead of the entry
  logic                tbl_rst [n_tests];
  logic [RESULT_W-1:0] tbl_res [n_tests];

  task automatic add_entry(input int i, input logic [name_w-1:0] name,
                           input logic [num_req-1:0] req, input int gap,
                           input logic rst, input logic [RESULT_W-1:0] res);
    tbl_name[i] = name;
    tbl_req[i]  = req;
    tbl_gap[i]  = gap;
    tbl_rst[i]  = rst;
    tbl_res[i]  = res;
  endtask

  task automatic fill_table();
    add_entry(0, "single_0", 5'b00001, 0, 1'b0, RES_SOLE);
    add_entry(1, "single_3", 5'b01000, 2, 1'b0, RES_SOLE);
    add_entry(2, "single_4", 5'b10000, 0, 1'b0, RES_SOLE);
    add_entry(3, "single_1", 5'b00010, 2, 1'b0, RES_SOLE);
    add_entry(4, "single_2", 5'b00100, 0, 1'b0, RES_SOLE);
    // leaves the pointer at 0 for the full sweep
    add_entry(5, "ptr_to_0", 5'b10000, 0, 1'b0, RES_SOLE);
    add_entry(6, "rr_all_0", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(7, "rr_all_1", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(8, "rr_all_2", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(9, "rr_all_3", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(10, "rr_all_4", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(11, "rr_all_5", 5'b11111, 0, 1'b0, RES_CONTENDED);
    // grant to 3, then {1,3} must wrap to 1
    add_entry(12, "pre_wrap", 5'b01000, 2, 1'b0, RES_SOLE);
    add_entry(13, "wrap_1_3", 5'b01010, 0, 1'b0, RES_CONTENDED);
    add_entry(14, "idle_a", 5'b00000, 0, 1'b0, RES_IDLE);
    add_entry(15, "idle_b", 5'b00000, 2, 1'b0, RES_IDLE);
    add_entry(16, "after_idle", 5'b11111, 0, 1'b0, RES_CONTENDED);
    add_entry(17, "reset_all", 5'b11111, 2, 1'b1, RES_CONTENDED);
    add_entry(18, "post_reset", 5'b00100, 0, 1'b0, RES_SOLE);
  endtask

  // strobe cycle, gap, and drain plus pulse for reset entries
  function automatic int table_cycles();
    int total;
    total = 2;
    for (int i = 0; i < n_tests; i++) begin
      total += 1 + tbl_gap[i] + (tbl_rst[i] ? 8 : 0);
    end
    return total;
  endfunction

  // --------------------
  // payload source
  // --------------------

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per payload bit
  task automatic make_payload(output logic [num_req*data_w-1:0] word);
    for (int b = 0; b < num_req * data_w; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word[b]    = lfsr_state[0];
    end
  endtask

  task automatic run_watchdog();
    int limit;
    limit = table_cycles() + 20;
    #(limit * 100);
    $display("watchdog expired after %0d cycles, pipeline did not drain", limit);
    $display("Test failed");
    $finish;
  endtask

  // --------------------
  // clock, DUT, checker
  // --------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  arb_pipe_top #(.num_req(num_req), .data_w(data_w), .idx_w(idx_w)) i_dut (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_req(in_req), .in_data(in_data),
    .out_valid(out_valid), .out_grant_valid(out_grant_valid), .out_index(out_index),
    .out_data(out_data), .out_result(out_result)
  );

  arb_pipe_checker #(.num_req(num_req), .data_w(data_w), .idx_w(idx_w), .name_w(name_w))
    i_checker (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_req(in_req), .in_data(in_data),
    .out_valid(out_valid), .out_grant_valid(out_grant_valid), .out_index(out_index),
    .out_data(out_data), .out_result(out_result), .test_name(cur_name),
    .exp_result(cur_exp), .err_count(err_count), .chk_count(chk_count), .pending(pending)
  );

  // --------------------
  // main sequence
  // --------------------

  initial begin
    logic [num_req*data_w-1:0] payload;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_req     = '0;
    in_data    = '0;
    cur_name   = '0;
    cur_exp    = RES_IDLE;
    tb_errs    = 0;
    lfsr_state = lfsr_seed;
    fill_table();
    fork
      run_watchdog();
    join_none
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      if (tbl_rst[i]) begin
        // let the pipeline empty, then pulse reset
        @(posedge clk);
        in_valid <= 1'b0;
        in_req   <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
      end
      make_payload(payload);
      @(posedge clk);
      in_valid <= 1'b1;
      in_req   <= tbl_req[i];
      in_data  <= payload;
      cur_name <= tbl_name[i];
      cur_exp  <= tbl_res[i];
      repeat (tbl_gap[i]) begin
        @(posedge clk);
        in_valid <= 1'b0;
        in_req   <= '0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    in_req   <= '0;
    @(posedge clk);
    // watchdog covers a pipeline that never empties
    wait (pending == 0);
    @(posedge clk);
    if (chk_count != n_tests) begin
      $display("only %0d of %0d arbitrations produced a result", chk_count, n_tests);
      tb_errs++;
    end
    $display("checks %0d, checker errors %0d, testbench errors %0d",
             chk_count, err_count, tb_errs);
    if (err_count == 0 && tb_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : arb_pipe_tb

`default_nettype wire

// File: build.f
verilog/arb_dims_pkg.sv
verilog/arb_result_pkg.sv
verilog/req_capture_stage.sv
verilog/rr_grant_stage.sv
verilog/grant_encode_stage.sv
verilog/payload_select_stage.sv
verilog/arb_pipe_top.sv
tests/arb_pipe_props.sv
tests/arb_pipe_checker.sv
tests/arb_pipe_tb.sv

// File: Makefile
# Verilator flow for the arbitration pipeline

VERILATOR ?= verilator
TOP       := arb_pipe_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --timing --assert
PASS_MSG  := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message shows up as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
